// File: logic/mem_chip_settings.svh
// Memory chip fabric settings
// Widths, the local memory window and the outbound D2D buffer depth

`ifndef MEM_CHIP_SETTINGS_SVH
`define MEM_CHIP_SETTINGS_SVH

// Host address and data
`define ADDR_WIDTH 48
`define CHIP_ID_WIDTH 8
`define DATA_WIDTH 32

// Local SRAM window, offset within the chip-local 40-bit space
`define MEM_BASE_OFFSET 40'h00_8000_0000
`define MEM_SIZE_BYTES 4096

// Word index into the bank
`define MEM_WORD_ADDR_WIDTH ($clog2(`MEM_SIZE_BYTES / (`DATA_WIDTH / 8)))

// Posted remote writes waiting for the link
`define D2D_FIFO_DEPTH 4

`endif

// File: logic/mem_chip_pkg.sv
// Memory chip fabric types
// Address, data, chip ID, routing and D2D flit definitions

`include "mem_chip_settings.svh"

package mem_chip_pkg;

  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DATA_WIDTH-1:0] data_t;
  typedef logic [`DATA_WIDTH/8-1:0] sel_t;
  typedef logic [`CHIP_ID_WIDTH-1:0] chip_id_t;

  // Chip-local part of the address
  typedef logic [`ADDR_WIDTH-`CHIP_ID_WIDTH-1:0] offset_t;

  // Where an accepted host access goes
  typedef enum logic [1:0] {
    ROUTE_LOCAL     = 2'd0,
    ROUTE_REMOTE_WR = 2'd1,
    ROUTE_ERROR     = 2'd2
  } route_e;

  // One posted write on the die-to-die link, 84 bits
  typedef struct packed {
    chip_id_t dst_chip_id;
    offset_t  offset;
    data_t    data;
    sel_t     sel;
  } d2d_flit_t;

endpackage

// File: logic/chip_addr_decoder.sv
// Chip address decoder
// Wishbone classic slave front end. Sends each access to the local SRAM bank,
// posts remote writes into the D2D FIFO, or answers with an error.

`timescale 1ns/1ns
`include "mem_chip_settings.svh"

module chip_addr_decoder (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  mem_chip_pkg::chip_id_t           chip_id_i,
  input  logic                             wb_cyc_i,
  input  logic                             wb_stb_i,
  input  logic                             wb_we_i,
  input  mem_chip_pkg::addr_t              wb_adr_i,
  input  mem_chip_pkg::data_t              wb_dat_i,
  input  mem_chip_pkg::sel_t               wb_sel_i,
  output mem_chip_pkg::data_t              wb_dat_o,
  output logic                             wb_ack_o,
  output logic                             wb_err_o,
  output logic                             mem_req_o,
  output logic                             mem_we_o,
  output logic [`MEM_WORD_ADDR_WIDTH-1:0]  mem_word_addr_o,
  output mem_chip_pkg::data_t              mem_wdata_o,
  output mem_chip_pkg::sel_t               mem_sel_o,
  input  mem_chip_pkg::data_t              mem_rdata_i,
  input  logic                             mem_ack_i,
  output logic                             push_valid_o,
  output mem_chip_pkg::d2d_flit_t          push_payload_o,
  input  logic                             push_ready_i
);

  localparam mem_chip_pkg::offset_t MemEnd = `MEM_BASE_OFFSET + `MEM_SIZE_BYTES;

  mem_chip_pkg::chip_id_t chip_id_q;
  mem_chip_pkg::chip_id_t adr_chip_id;
  mem_chip_pkg::offset_t  adr_offset;
  mem_chip_pkg::offset_t  local_offset;
  mem_chip_pkg::route_e   route;
  logic                   in_window;
  logic                   req_new;
  logic                   busy_q;
  logic                   push_ack_q;
  logic                   err_q;

  // Own ID, sampled only while reset is held
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      chip_id_q <= chip_id_i;
    end
  end

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  assign adr_chip_id  = wb_adr_i[`ADDR_WIDTH-1 -: `CHIP_ID_WIDTH];
  assign adr_offset   = wb_adr_i[`ADDR_WIDTH-`CHIP_ID_WIDTH-1:0];
  assign local_offset = adr_offset - `MEM_BASE_OFFSET;
  assign in_window    = (adr_offset >= `MEM_BASE_OFFSET) && (adr_offset < MemEnd);

  always_comb begin
    if (adr_chip_id != chip_id_q) begin
      // Remote reads need the inbound path
      if (wb_we_i) begin
        route = mem_chip_pkg::ROUTE_REMOTE_WR;
      end else begin
        route = mem_chip_pkg::ROUTE_ERROR;
      end
    end else if (in_window) begin
      route = mem_chip_pkg::ROUTE_LOCAL;
    end else begin
      route = mem_chip_pkg::ROUTE_ERROR;
    end
  end

  // Busy masks the strobe until the host drops it
  assign req_new = wb_cyc_i && wb_stb_i && !busy_q;

  //////////////////////////////////////////////////
  // Dispatch and response
  //////////////////////////////////////////////////

  assign push_valid_o   = req_new && (route == mem_chip_pkg::ROUTE_REMOTE_WR);
  assign push_payload_o = '{dst_chip_id: adr_chip_id, offset: adr_offset,
                            data: wb_dat_i, sel: wb_sel_i};

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      mem_req_o  <= 1'b0;
      push_ack_q <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      mem_req_o  <= req_new && (route == mem_chip_pkg::ROUTE_LOCAL);
      push_ack_q <= push_valid_o && push_ready_i;
      err_q      <= req_new && (route == mem_chip_pkg::ROUTE_ERROR);
      if (!(wb_cyc_i && wb_stb_i)) begin
        busy_q <= 1'b0;
      end else if (req_new && (route != mem_chip_pkg::ROUTE_REMOTE_WR || push_ready_i)) begin
        busy_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_new) begin
      mem_we_o        <= wb_we_i;
      mem_word_addr_o <= local_offset[`MEM_WORD_ADDR_WIDTH+1:2];
      mem_wdata_o     <= wb_dat_i;
      mem_sel_o       <= wb_sel_i;
    end
  end

  assign wb_ack_o = mem_ack_i || push_ack_q;
  assign wb_err_o = err_q;
  assign wb_dat_o = mem_rdata_i;

  a_ack_err_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_ack_o && wb_err_o))
    else $error("ack and err high together");

  // A stalled push holds until the FIFO takes it
  a_push_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_valid_o && !push_ready_i |=> push_valid_o && $stable(push_payload_o))
    else $error("pending push dropped or changed");

endmodule

// File: logic/mem_bank.sv
// Local SRAM bank
// Word-wide storage with per-byte write selects; read data and ack
// are registered one cycle after the request.

`timescale 1ns/1ns
`include "mem_chip_settings.svh"

module mem_bank (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            req_i,
  input  logic                            we_i,
  input  logic [`MEM_WORD_ADDR_WIDTH-1:0] word_addr_i,
  input  mem_chip_pkg::data_t             wdata_i,
  input  mem_chip_pkg::sel_t              sel_i,
  output mem_chip_pkg::data_t             rdata_o,
  output logic                            ack_o
);

  localparam int NumBytes = `DATA_WIDTH / 8;
  localparam int NumWords = `MEM_SIZE_BYTES / NumBytes;

  mem_chip_pkg::data_t mem_q [NumWords];

  // Storage and read port
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < NumBytes; b++) begin
          if (sel_i[b]) begin
            mem_q[word_addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
      // Old contents on a write, the ack is all that matters there
      rdata_o <= mem_q[word_addr_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= req_i;
    end
  end

  // The decoder keeps one access in flight
  a_no_req_on_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |-> !req_i)
    else $error("bank request while ack pending");

endmodule

// File: logic/d2d_tx_fifo.sv
// Outbound D2D FIFO
// Circular buffer for posted remote writes with one push and one pop per cycle

`timescale 1ns/1ns
`include "mem_chip_settings.svh"

module d2d_tx_fifo #(
  parameter type payload_t = logic,
  parameter int  Depth     = `D2D_FIFO_DEPTH
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_valid_i,
  input  payload_t push_payload_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_payload_o,
  input  logic     pop_ready_i
);

  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);

  payload_t              mem_q [Depth];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [CntWidth-1:0]   count_q;
  logic                  push_fire;
  logic                  pop_fire;

  assign push_ready_o  = (count_q != CntWidth'(Depth));
  assign pop_valid_o   = (count_q != '0);
  assign pop_payload_o = mem_q[rd_ptr_q];

  assign push_fire = push_valid_i && push_ready_o;
  assign pop_fire  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem_q[wr_ptr_q] <= push_payload_i;
    end
  end

  // Pointers wrap at Depth and the count tracks occupancy
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_fire, pop_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // The producer keeps its entry while the FIFO is full
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_valid_i && !push_ready_o |=> push_valid_i)
    else $error("push withdrawn while FIFO full");

  // Pointers meet whenever the FIFO is empty
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !pop_valid_o |-> (rd_ptr_q == wr_ptr_q))
    else $error("pointers differ while FIFO empty");

endmodule

// File: logic/d2d_tx_link.sv
// D2D link transmitter
// One-entry output register that pulls the FIFO head and offers it
// to the partner chip under an rts/cts handshake.

`timescale 1ns/1ns

module d2d_tx_link (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    pop_valid_i,
  input  mem_chip_pkg::d2d_flit_t pop_payload_i,
  output logic                    pop_ready_o,
  output mem_chip_pkg::d2d_flit_t d2d_flit_o,
  output logic                    d2d_rts_o,
  input  logic                    d2d_cts_i
);

  mem_chip_pkg::d2d_flit_t flit_q;
  logic                    valid_q;
  logic                    handoff;
  logic                    load;

  // Register frees up in the same cycle the partner takes the flit
  assign handoff     = valid_q && d2d_cts_i;
  assign pop_ready_o = !valid_q || handoff;
  assign load        = pop_valid_i && pop_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (handoff) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      flit_q <= pop_payload_i;
    end
  end

  assign d2d_flit_o = flit_q;
  assign d2d_rts_o  = valid_q;

  a_flit_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d2d_rts_o && !d2d_cts_i |=> d2d_rts_o && $stable(d2d_flit_o))
    else $error("flit changed while stalled");

endmodule

// File: logic/hemaia_mem_chip.sv
// HeMAiA memory chip fabric
// Wishbone host port in front of a local SRAM bank and one outbound
// die-to-die link for posted remote writes.

`timescale 1ns/1ns
`include "mem_chip_settings.svh"

module hemaia_mem_chip (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  mem_chip_pkg::chip_id_t  chip_id_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  mem_chip_pkg::addr_t     wb_adr_i,
  input  mem_chip_pkg::data_t     wb_dat_i,
  input  mem_chip_pkg::sel_t      wb_sel_i,
  output mem_chip_pkg::data_t     wb_dat_o,
  output logic                    wb_ack_o,
  output logic                    wb_err_o,
  output mem_chip_pkg::d2d_flit_t d2d_flit_o,
  output logic                    d2d_rts_o,
  input  logic                    d2d_cts_i
);

  logic                            mem_req;
  logic                            mem_we;
  logic [`MEM_WORD_ADDR_WIDTH-1:0] mem_word_addr;
  mem_chip_pkg::data_t             mem_wdata;
  mem_chip_pkg::sel_t              mem_sel;
  mem_chip_pkg::data_t             mem_rdata;
  logic                            mem_ack;

  logic                    push_valid;
  logic                    push_ready;
  mem_chip_pkg::d2d_flit_t push_payload;
  logic                    pop_valid;
  logic                    pop_ready;
  mem_chip_pkg::d2d_flit_t pop_payload;

  //////////////////////////////////////////////////
  // Host front end and local memory
  //////////////////////////////////////////////////

  chip_addr_decoder i_chip_addr_decoder (
    .clk_i, .rst_ni, .chip_id_i,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i,
    .wb_dat_o, .wb_ack_o, .wb_err_o,
    .mem_req_o       (mem_req),
    .mem_we_o        (mem_we),
    .mem_word_addr_o (mem_word_addr),
    .mem_wdata_o     (mem_wdata),
    .mem_sel_o       (mem_sel),
    .mem_rdata_i     (mem_rdata),
    .mem_ack_i       (mem_ack),
    .push_valid_o    (push_valid),
    .push_payload_o  (push_payload),
    .push_ready_i    (push_ready)
  );

  mem_bank i_mem_bank (
    .clk_i, .rst_ni,
    .req_i       (mem_req),
    .we_i        (mem_we),
    .word_addr_i (mem_word_addr),
    .wdata_i     (mem_wdata),
    .sel_i       (mem_sel),
    .rdata_o     (mem_rdata),
    .ack_o       (mem_ack)
  );

  //////////////////////////////////////////////////
  // Outbound D2D path
  //////////////////////////////////////////////////

  d2d_tx_fifo #(
    .payload_t (mem_chip_pkg::d2d_flit_t),
    .Depth     (`D2D_FIFO_DEPTH)
  ) i_d2d_tx_fifo (
    .clk_i, .rst_ni,
    .push_valid_i   (push_valid),
    .push_payload_i (push_payload),
    .push_ready_o   (push_ready),
    .pop_valid_o    (pop_valid),
    .pop_payload_o  (pop_payload),
    .pop_ready_i    (pop_ready)
  );

  d2d_tx_link i_d2d_tx_link (
    .clk_i, .rst_ni,
    .pop_valid_i   (pop_valid),
    .pop_payload_i (pop_payload),
    .pop_ready_o   (pop_ready),
    .d2d_flit_o, .d2d_rts_o, .d2d_cts_i
  );

endmodule

// File: verification/tb_hemaia_mem_chip.sv
// Memory chip fabric testbench
// Local SRAM, error, remote write and link back-pressure tests, checked by
// concurrent assertions against a memory model and an expected-flit list

`timescale 1ns/1ns
`include "mem_chip_settings.svh"

module tb_hemaia_mem_chip;

  localparam mem_chip_pkg::chip_id_t OwnChipId = 8'h12;
  // Some 50 accesses of about 5 cycles plus stalls and drains come to a few hundred
  localparam int TimeoutCycles = 3000;
  localparam int MaxFlits = 32;

  logic                    clk_i;
  logic                    rst_ni;
  mem_chip_pkg::chip_id_t  chip_id_i;
  logic                    wb_cyc_i;
  logic                    wb_stb_i;
  logic                    wb_we_i;
  mem_chip_pkg::addr_t     wb_adr_i;
  mem_chip_pkg::data_t     wb_dat_i;
  mem_chip_pkg::sel_t      wb_sel_i;
  mem_chip_pkg::data_t     wb_dat_o;
  logic                    wb_ack_o;
  logic                    wb_err_o;
  mem_chip_pkg::d2d_flit_t d2d_flit_o;
  logic                    d2d_rts_o;
  logic                    d2d_cts_i;

  // Reference state
  mem_chip_pkg::data_t     mem_model [`MEM_SIZE_BYTES/4];
  mem_chip_pkg::d2d_flit_t exp_flits [MaxFlits];
  int                      flit_wr = 0;
  int                      flit_rd = 0;
  logic                    exp_ack;
  logic                    exp_err;
  int                      exp_lat;
  logic                    chk_rdata;
  mem_chip_pkg::data_t     exp_rdata;
  int                      lat_cnt = 0;
  int                      cycle_cnt = 0;
  int                      errors;
  int                      err_base;
  int                      test_cnt;
  logic [31:0]             lcg_state;

  hemaia_mem_chip hemaia_mem_chip_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic mem_chip_pkg::data_t merge_bytes(input mem_chip_pkg::data_t old_word,
      input mem_chip_pkg::data_t new_word, input mem_chip_pkg::sel_t sel);
    mem_chip_pkg::data_t res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic mem_chip_pkg::addr_t local_addr(input int idx);
    return {OwnChipId, `MEM_BASE_OFFSET + 40'(idx * 4)};
  endfunction

  // Chip IDs 0x20 to 0x2f and so never our own
  function automatic mem_chip_pkg::addr_t remote_addr();
    return {8'h20 + 8'(next_rand() % 16), 8'(next_rand()), next_rand()};
  endfunction

  task automatic log_error(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic report_test(input string name);
    test_cnt++;
    $display("Test %0d %s finished with %0d errors", test_cnt, name, errors - err_base);
    err_base = errors;
  endtask

  //////////////////////////////////////////////////
  // Wishbone host
  //////////////////////////////////////////////////

  task automatic start_access(input logic we, input mem_chip_pkg::addr_t adr,
      input mem_chip_pkg::data_t dat, input mem_chip_pkg::sel_t sel);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
  endtask

  task automatic finish_access();
    do begin
      @(posedge clk_i);
      #1;
    end while (!wb_ack_o && !wb_err_o);
    // The response is sampled on the next edge and the strobe drops after it
    @(posedge clk_i);
    #1;
    exp_ack   = 1'b0;
    exp_err   = 1'b0;
    chk_rdata = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    @(posedge clk_i);
    #1;
  endtask

  task automatic local_write(input int idx, input mem_chip_pkg::data_t dat,
      input mem_chip_pkg::sel_t sel);
    mem_model[idx] = merge_bytes(mem_model[idx], dat, sel);
    exp_ack = 1'b1;
    exp_lat = 2;
    start_access(1'b1, local_addr(idx), dat, sel);
    finish_access();
  endtask

  task automatic local_read(input int idx);
    exp_rdata = mem_model[idx];
    chk_rdata = 1'b1;
    exp_ack   = 1'b1;
    exp_lat   = 2;
    start_access(1'b0, local_addr(idx), '0, 4'hf);
    finish_access();
  endtask

  task automatic error_access(input logic we, input mem_chip_pkg::addr_t adr);
    exp_err = 1'b1;
    exp_lat = 1;
    start_access(we, adr, next_rand(), 4'hf);
    finish_access();
  endtask

  task automatic queue_flit(input mem_chip_pkg::addr_t adr, input mem_chip_pkg::data_t dat,
      input mem_chip_pkg::sel_t sel);
    exp_flits[flit_wr] = '{dst_chip_id: adr[`ADDR_WIDTH-1 -: `CHIP_ID_WIDTH],
                           offset: adr[`ADDR_WIDTH-`CHIP_ID_WIDTH-1:0], data: dat, sel: sel};
    flit_wr++;
  endtask

  task automatic remote_write(input mem_chip_pkg::addr_t adr, input mem_chip_pkg::data_t dat,
      input mem_chip_pkg::sel_t sel);
    queue_flit(adr, dat, sel);
    exp_ack = 1'b1;
    exp_lat = 1;
    start_access(1'b1, adr, dat, sel);
    finish_access();
  endtask

  task automatic wait_drained();
    while (flit_rd != flit_wr) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_local();
    int idx [8];
    for (int i = 0; i < 8; i++) begin
      idx[i] = i * 64 + int'(next_rand() % 64);
      local_write(idx[i], next_rand(), 4'hf);
      local_write(idx[i], next_rand(), 4'(next_rand()));
    end
    for (int i = 0; i < 8; i++) begin
      local_read(idx[i]);
    end
    report_test("local writes and reads");
  endtask

  task automatic test_errors();
    error_access(1'b0, {OwnChipId, 40'h00_0000_1000});
    error_access(1'b1, {OwnChipId, 40'h00_0000_1000});
    error_access(1'b1, {OwnChipId, `MEM_BASE_OFFSET + 40'(`MEM_SIZE_BYTES)});
    error_access(1'b0, {8'h55, `MEM_BASE_OFFSET});
    report_test("unmapped and remote-read errors");
  endtask

  task automatic test_remote();
    for (int i = 0; i < 6; i++) begin
      remote_write(remote_addr(), next_rand(), 4'(next_rand()));
    end
    wait_drained();
    report_test("remote writes on the link");
  endtask

  task automatic test_backpressure();
    mem_chip_pkg::addr_t adr;
    mem_chip_pkg::data_t dat;
    mem_chip_pkg::sel_t  sel;
    d2d_cts_i = 1'b0;
    for (int i = 0; i < 5; i++) begin
      remote_write(remote_addr(), next_rand(), 4'(next_rand()));
    end
    // Link register and FIFO are full so this one must wait
    adr = remote_addr();
    dat = next_rand();
    sel = 4'(next_rand());
    queue_flit(adr, dat, sel);
    start_access(1'b1, adr, dat, sel);
    repeat (10) begin
      @(posedge clk_i);
      #1;
    end
    // Ack follows ten stalled edges plus the handoff edge and the push edge
    exp_ack   = 1'b1;
    exp_lat   = 12;
    d2d_cts_i = 1'b1;
    finish_access();
    wait_drained();
    report_test("back-pressure");
  endtask

  task automatic test_reset_id();
    // One flit held on the link and one in the FIFO when reset hits
    d2d_cts_i = 1'b0;
    remote_write(remote_addr(), next_rand(), 4'hf);
    remote_write(remote_addr(), next_rand(), 4'hf);
    rst_ni = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni    = 1'b1;
    chip_id_i = 8'h34;
    // Reset drops the posted writes
    flit_wr   = flit_rd;
    d2d_cts_i = 1'b1;
    local_write(7, next_rand(), 4'hf);
    local_read(7);
    // Own ID is still 0x12 so 0x34 counts as a remote chip
    remote_write({8'h34, 40'h12_3456_7890}, next_rand(), 4'hf);
    wait_drained();
    report_test("reset and chip ID");
  endtask

  //////////////////////////////////////////////////
  // Checkers
  //////////////////////////////////////////////////

  // Edges on which the strobe was sampled high in this access
  always @(posedge clk_i) begin
    if (wb_cyc_i && wb_stb_i) begin
      lat_cnt <= lat_cnt + 1;
    end else begin
      lat_cnt <= 0;
    end
  end

  always @(posedge clk_i) begin
    if (d2d_rts_o && d2d_cts_i) begin
      flit_rd <= flit_rd + 1;
    end
  end

  a_ack_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |-> exp_ack && lat_cnt == exp_lat)
    else log_error($sformatf("unexpected ack after %0d cycles", $sampled(lat_cnt)));

  a_err_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_err_o |-> exp_err && lat_cnt == exp_lat)
    else log_error($sformatf("unexpected err after %0d cycles", $sampled(lat_cnt)));

  a_read_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o && chk_rdata |-> wb_dat_o == exp_rdata)
    else log_error($sformatf("read data %h, expected %h", $sampled(wb_dat_o), exp_rdata));

  a_flit_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d2d_rts_o && d2d_cts_i |-> flit_rd < flit_wr && d2d_flit_o == exp_flits[flit_rd])
    else log_error($sformatf("flit %h, expected %h", $sampled(d2d_flit_o),
                             exp_flits[$sampled(flit_rd)]));

  a_flit_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d2d_rts_o && !d2d_cts_i |=> d2d_rts_o && $stable(d2d_flit_o))
    else log_error("stalled flit changed or rts dropped");

  a_reset_idle: assert property (@(posedge clk_i)
    !rst_ni |=> !wb_ack_o && !wb_err_o && !d2d_rts_o)
    else log_error("ack, err or rts high after reset");

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    rst_ni    = 1'b0;
    chip_id_i = OwnChipId;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    wb_sel_i  = '0;
    d2d_cts_i = 1'b1;
    exp_ack   = 1'b0;
    exp_err   = 1'b0;
    exp_lat   = 0;
    chk_rdata = 1'b0;
    exp_rdata = '0;
    errors    = 0;
    err_base  = 0;
    test_cnt  = 0;
    lcg_state = 32'hcd8b_8500;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_local();
    test_errors();
    test_remote();
    test_backpressure();
    test_reset_id();
    $display("Tests run: %0d, errors: %0d", test_cnt, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+logic
logic/mem_chip_pkg.sv
logic/chip_addr_decoder.sv
logic/mem_bank.sv
logic/d2d_tx_fifo.sv
logic/d2d_tx_link.sv
logic/hemaia_mem_chip.sv
verification/tb_hemaia_mem_chip.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_hemaia_mem_chip \
  -Mdir obj_dir -o sim_tb || { echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || grep -q "Simulation PASSED" sim.log || exit 1
exit 0
